//--- sources.f
+incdir+design
design/fifo_pkg.sv
design/fifo_port_if.sv
design/fifo_dpram.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/fifo_level_cfg.sv
design/fifo_cdc_top.sv
sim/tb_fifo_cdc.sv

//--- Makefile
BIN  := obj_dir/Vtb_fifo_cdc
SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) design/fifo_macros.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_fifo_cdc -o Vtb_fifo_cdc

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_fifo_cdc.sv
`timescale 1ns/100ps
`default_nettype none
`include "fifo_macros.svh"

module tb_fifo_cdc;
    import fifo_pkg::*;

    localparam int RD_PERIOD = 40;
    localparam int WR_PERIOD = 28;              // Drifts against rd_clk
    localparam int DEPTH     = `FIFO_DEPTH;
    localparam int TOTAL_CYC = 1080;            // Sum of all phase lengths in wr_clk cycles
    localparam int MARGIN_NS = 100 * RD_PERIOD; // Settling, config and reset

    logic     rd_clk = 1'b0;
    logic     wr_clk = 1'b0;
    logic     RST, wr_en, rd_en, cfg_we;
    data_t    din, dout;
    logic     full, empty, almost_empty, almost_full;
    level_t   wcount, rcount, cfg_wdata, cfg_rdata;
    cfg_sel_t cfg_sel;

    data_t  model [$];                  // Every accepted word, in order
    int     push_cnt, pop_cnt, model_size, n_errors;
    data_t  head_word;
    logic   settled, rb_chk;            // Quiet window and readback strobes
    level_t exp_low, exp_high, exp_rb;  // Expected marks and readback

    always #(RD_PERIOD/2) rd_clk = ~rd_clk;
    always #(WR_PERIOD/2) wr_clk = ~wr_clk;

    fifo_cdc_top UUT (.*);

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    always @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            model.delete();
            push_cnt <= 0;
        end else if (wr_en && !full) begin    // Accepted at the ports
            model.push_back(din);
            push_cnt <= push_cnt + 1;
        end
    end

    always @(posedge rd_clk or posedge RST) begin
        if (RST) pop_cnt <= 0;
        else if (rd_en && !empty) pop_cnt <= pop_cnt + 1;   // Pop by index
    end

    assign model_size = push_cnt - pop_cnt;
    assign head_word  = model[pop_cnt];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_order : assert property (@(posedge rd_clk) disable iff (RST)
        (rd_en && !empty) |-> (model_size > 0 && dout == head_word))
    else begin
        n_errors++;
        $display("FAILED %0t: dout %h, expected %h", $time, dout, head_word);
    end

    // Full may lag a read but must be up whenever the model is full
    a_bound : assert property (@(posedge wr_clk) disable iff (RST)
        model_size <= DEPTH && (model_size < DEPTH || full))
    else begin
        n_errors++;
        $display("FAILED %0t: model %0d words, full %b", $time, model_size, full);
    end

    a_empty : assert property (@(posedge rd_clk) disable iff (RST)
        (model_size == 0) |-> empty)   // Empty may lag a write but never a read
    else begin
        n_errors++;
        $display("FAILED %0t: empty low with no data", $time);
    end

    a_counts : assert property (@(posedge rd_clk) disable iff (RST)
        settled |-> (int'(wcount) == model_size && int'(rcount) == model_size
                     && empty == (model_size == 0)))
    else begin
        n_errors++;
        $display("FAILED %0t: wcount %0d rcount %0d, model %0d",
                 $time, wcount, rcount, model_size);
    end

    a_marks : assert property (@(posedge rd_clk) disable iff (RST)
        settled |-> (almost_empty == (model_size <= int'(exp_low))
                     && almost_full == (model_size >= int'(exp_high))))
    else begin
        n_errors++;
        $display("FAILED %0t: ae %b af %b at %0d words",
                 $time, almost_empty, almost_full, model_size);
    end

    a_readback : assert property (@(posedge rd_clk) disable iff (RST)
        rb_chk |-> cfg_rdata == exp_rb)
    else begin
        n_errors++;
        $display("FAILED %0t: cfg_rdata %0d, expected %0d", $time, cfg_rdata, exp_rb);
    end

    a_reset : assert property (@(posedge rd_clk)
        $fell(RST) |-> (!full && empty && wcount == 0 && rcount == 0
                        && almost_empty && !almost_full))
    else begin
        n_errors++;
        $display("FAILED %0t: state after reset is wrong", $time);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Random strobes on both sides for ncyc wr_clk cycles
    task automatic run_phase(input int wr_pct, input int rd_pct, input int ncyc);
        realtime t_end;
        t_end = $realtime + ncyc * WR_PERIOD;
        fork
            while ($realtime < t_end) begin
                @(posedge wr_clk) #2;
                wr_en = ($urandom % 100) < wr_pct;
                din   = data_t'($urandom);
            end
            while ($realtime < t_end) begin
                @(posedge rd_clk) #2;
                rd_en = ($urandom % 100) < rd_pct;
            end
        join
    endtask

    // Quiet for 4 rd_clk cycles, then open the count and flag checks
    task automatic settle_and_check();
        @(posedge wr_clk) #2 wr_en = 1'b0;
        @(posedge rd_clk) #2 rd_en = 1'b0;
        repeat (4) @(posedge rd_clk);
        #2 settled = 1'b1;
        repeat (2) @(posedge rd_clk);
        #2 settled = 1'b0;
    endtask

    // exp_val is what the register should hold after the write
    task automatic write_mark(input cfg_sel_t sel, input level_t val, input level_t exp_val);
        @(posedge rd_clk) #2;
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = val;
        exp_rb    = exp_val;
        if (sel == SEL_HIGH) begin
            exp_high = exp_val;
        end else begin
            exp_low = exp_val;
        end
        @(posedge rd_clk) #2;
        cfg_we = 1'b0;
        rb_chk = 1'b1;                  // Sampled on the next edge
        @(posedge rd_clk) #2 rb_chk = 1'b0;
    endtask

    task automatic apply_reset();
        RST      = 1'b1;
        exp_low  = 2;
        exp_high = level_t'(DEPTH - 2);
        repeat (5) @(posedge rd_clk);
        #2 RST = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hf0762d19));
        RST       = 1'b1;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        din       = '0;
        cfg_we    = 1'b0;
        cfg_sel   = SEL_LOW;
        cfg_wdata = '0;
        settled   = 1'b0;
        rb_chk    = 1'b0;
        exp_rb    = '0;
        n_errors  = 0;
        #2 apply_reset();
        settle_and_check();
        run_phase(80, 20, 200);         // Write-heavy
        settle_and_check();
        run_phase(100, 0, 40);          // Fill and write while full
        settle_and_check();
        run_phase(20, 80, 200);         // Read-heavy
        settle_and_check();
        run_phase(0, 100, 40);          // Drain and read while empty
        settle_and_check();
        run_phase(50, 50, 300);         // Balanced
        settle_and_check();
        write_mark(SEL_LOW, 5, 5);
        write_mark(SEL_HIGH, 11, 11);
        run_phase(60, 40, 150);
        settle_and_check();
        write_mark(SEL_HIGH, 25, level_t'(DEPTH));     // Clamped to depth
        write_mark(SEL_LOW, 0, 0);
        run_phase(40, 60, 150);
        settle_and_check();
        @(posedge rd_clk) #2 apply_reset();              // With data inside
        settle_and_check();
        $display("Summary: %0d check errors, 0 timeouts", n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the phase lengths
    initial begin
        #(TOTAL_CYC * WR_PERIOD + MARGIN_NS);
        $display("Timeout: the test sequence did not finish in time");
        $display("Summary: %0d check errors, 1 timeouts", n_errors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fifo_cdc_top.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_cdc_top (
    input  logic                wr_clk,
    input  logic                rd_clk,
    input  logic                RST,        // Clears both domains
    // Write side
    input  logic                wr_en,
    input  fifo_pkg::data_t     din,
    output logic                full,
    output fifo_pkg::level_t    wcount,
    // Read side
    input  logic                rd_en,
    output fifo_pkg::data_t     dout,
    output logic                empty,
    output fifo_pkg::level_t    rcount,
    output logic                almost_empty,
    output logic                almost_full,
    // Watermark configuration, rd_clk domain
    input  logic                cfg_we,
    input  fifo_pkg::cfg_sel_t  cfg_sel,
    input  fifo_pkg::level_t    cfg_wdata,
    output fifo_pkg::level_t    cfg_rdata
);
    import fifo_pkg::*;

    level_t low_mark;               // Config to read controller
    level_t high_mark;

    //////////////////////////////////////////////////////////////////////
    // Internal bus and blocks
    //////////////////////////////////////////////////////////////////////

    fifo_port_if port_if ();

    fifo_dpram u_dpram (
        .wr_clk (wr_clk),
        .mem    (port_if.ram)
    );

    fifo_wr_ctrl u_wr_ctrl (
        .wr_clk (wr_clk),
        .RST    (RST),
        .wr_en  (wr_en),
        .din    (din),
        .full   (full),
        .wcount (wcount),
        .wp     (port_if.wr_side)
    );

    fifo_rd_ctrl u_rd_ctrl (
        .rd_clk       (rd_clk),
        .RST          (RST),
        .rd_en        (rd_en),
        .low_mark     (low_mark),
        .high_mark    (high_mark),
        .dout         (dout),
        .empty        (empty),
        .rcount       (rcount),
        .almost_empty (almost_empty),
        .almost_full  (almost_full),
        .rp           (port_if.rd_side)
    );

    // Sits beside the read controller it steers
    fifo_level_cfg u_level_cfg (
        .rd_clk    (rd_clk),
        .RST       (RST),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .low_mark  (low_mark),
        .high_mark (high_mark)
    );

endmodule

`default_nettype wire

//--- design/fifo_level_cfg.sv
`timescale 1ns/100ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_level_cfg (
    input  logic                rd_clk,
    input  logic                RST,
    input  logic                cfg_we,
    input  fifo_pkg::cfg_sel_t  cfg_sel,
    input  fifo_pkg::level_t    cfg_wdata,
    output fifo_pkg::level_t    cfg_rdata,
    output fifo_pkg::level_t    low_mark,
    output fifo_pkg::level_t    high_mark
);
    import fifo_pkg::*;

    localparam level_t LVL_MAX  = level_t'(`FIFO_DEPTH);
    localparam level_t LOW_RST  = level_t'(2);
    localparam level_t HIGH_RST = level_t'(`FIFO_DEPTH - 2);

    //////////////////////////////////////////////////////////////////////
    // Watermark registers
    //////////////////////////////////////////////////////////////////////

    level_t low_q;
    level_t high_q;
    level_t wdata_clamp;            // Limited to depth

    // Values above depth would pin both flags
    assign wdata_clamp = (cfg_wdata > LVL_MAX) ? LVL_MAX : cfg_wdata;

    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            low_q  <= LOW_RST;
            high_q <= HIGH_RST;
        end else if (cfg_we) begin
            if (cfg_sel == SEL_HIGH) begin
                high_q <= wdata_clamp;
            end else begin
                low_q  <= wdata_clamp;
            end
        end
    end

    assign low_mark  = low_q;
    assign high_mark = high_q;

    // Readback mux without a wait state
    assign cfg_rdata = (cfg_sel == SEL_HIGH) ? high_q : low_q;

    // In-range low mark is stored as written, never above depth
    a_low_range : assert property (
        @(posedge rd_clk) disable iff (RST)
        (cfg_we && cfg_sel == SEL_LOW) |=>
            (low_q <= LVL_MAX) && ($past(cfg_wdata) > LVL_MAX || low_q == $past(cfg_wdata))
    ) else $error("low watermark not stored within depth");

endmodule

`default_nettype wire

//--- design/fifo_rd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_rd_ctrl (
    input  logic            rd_clk,
    input  logic            RST,
    input  logic            rd_en,
    input  fifo_pkg::level_t low_mark,
    input  fifo_pkg::level_t high_mark,
    output fifo_pkg::data_t dout,
    output logic            empty,
    output fifo_pkg::level_t rcount,
    output logic            almost_empty,
    output logic            almost_full,
    fifo_port_if.rd_side    rp
);
    import fifo_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Read pointer
    //////////////////////////////////////////////////////////////////////

    ptr_t   rd_bin;                 // Points at the head word
    ptr_t   rd_bin_nxt;
    ptr_t   rd_gray_q;              // Crosses into wr_clk
    ptr_t   rd_gray_nxt;
    logic   rd_pop;                 // Accepted read

    assign rd_pop      = rd_en & ~empty;        // Reads while empty ignored
    assign rd_bin_nxt  = rd_bin + ptr_t'(rd_pop);
    assign rd_gray_nxt = bin2gray(rd_bin_nxt);

    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            rd_bin    <= '0;
            rd_gray_q <= '0;
        end else begin
            rd_bin    <= rd_bin_nxt;
            rd_gray_q <= rd_gray_nxt;
        end
    end

    assign rp.rd_addr = rd_bin[`FIFO_LSIZE-1:0];
    assign rp.rd_gray = rd_gray_q;
    assign dout       = rp.rd_data;     // Head word is valid while empty is low

    //////////////////////////////////////////////////////////////////////
    // Write pointer synchronizer
    //////////////////////////////////////////////////////////////////////

    ptr_t   wr_sync [`FIFO_SYNC_STAGES];
    ptr_t   wr_gray_s;
    ptr_t   wr_bin_s;

    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
                wr_sync[i] <= '0;
            end
        end else begin
            wr_sync[0] <= rp.wr_gray;   // First stage may go metastable
            for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
                wr_sync[i] <= wr_sync[i-1];
            end
        end
    end

    assign wr_gray_s = wr_sync[`FIFO_SYNC_STAGES-1];
    assign wr_bin_s  = gray2bin(wr_gray_s);

    //////////////////////////////////////////////////////////////////////
    // Empty, count and watermark flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            empty  <= 1'b1;
            rcount <= '0;
        end else begin
            empty  <= (rd_gray_nxt == wr_gray_s);       // Caught up with writer
            rcount <= level_t'(wr_bin_s - rd_bin_nxt);
        end
    end

    // One cycle behind rcount
    always_ff @(posedge rd_clk or posedge RST) begin
        if (RST) begin
            almost_empty <= 1'b1;
            almost_full  <= 1'b0;
        end else begin
            almost_empty <= (rcount <= low_mark);
            almost_full  <= (rcount >= high_mark);
        end
    end

    // Read pointer never overtakes the write pointer seen here
    a_no_pop_empty : assert property (
        @(posedge rd_clk) disable iff (RST)
        ptr_t'(wr_bin_s - rd_bin) <= ptr_t'(`FIFO_DEPTH)
    ) else $error("read pointer passed the write pointer");

    a_rcount_range : assert property (
        @(posedge rd_clk) disable iff (RST)
        rcount <= level_t'(`FIFO_DEPTH)
    ) else $error("rcount above depth");

endmodule

`default_nettype wire

//--- design/fifo_wr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_wr_ctrl (
    input  logic            wr_clk,
    input  logic            RST,
    input  logic            wr_en,
    input  fifo_pkg::data_t din,
    output logic            full,
    output fifo_pkg::level_t wcount,
    fifo_port_if.wr_side    wp
);
    import fifo_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Write pointer
    //////////////////////////////////////////////////////////////////////

    ptr_t   wr_bin;                 // Binary pointer with wrap bit on top
    ptr_t   wr_bin_nxt;
    ptr_t   wr_gray_q;              // Registered before it crosses
    ptr_t   wr_gray_nxt;
    logic   wr_push;                // Accepted write this cycle

    assign wr_push     = wr_en & ~full;     // Writes while full are dropped
    assign wr_bin_nxt  = wr_bin + ptr_t'(wr_push);
    assign wr_gray_nxt = bin2gray(wr_bin_nxt);

    always_ff @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            wr_bin    <= '0;
            wr_gray_q <= '0;
        end else begin
            wr_bin    <= wr_bin_nxt;
            wr_gray_q <= wr_gray_nxt;   // Only one bit flips per push
        end
    end

    // Memory port
    assign wp.wr_en_mem = wr_push;
    assign wp.wr_addr   = wr_bin[`FIFO_LSIZE-1:0];  // Drop wrap bit
    assign wp.wr_data   = din;
    assign wp.wr_gray   = wr_gray_q;

    //////////////////////////////////////////////////////////////////////
    // Read pointer synchronizer
    //////////////////////////////////////////////////////////////////////

    ptr_t   rd_sync [`FIFO_SYNC_STAGES];    // Flop chain into wr_clk
    ptr_t   rd_gray_s;                      // Last stage is safe to use
    ptr_t   rd_bin_s;
    ptr_t   rd_gray_full;                   // Top two bits flipped

    always_ff @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
                rd_sync[i] <= '0;
            end
        end else begin
            rd_sync[0] <= wp.rd_gray;
            for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
                rd_sync[i] <= rd_sync[i-1];
            end
        end
    end

    assign rd_gray_s = rd_sync[`FIFO_SYNC_STAGES-1];
    assign rd_bin_s  = gray2bin(rd_gray_s);

    // Full when write is one lap ahead of read
    assign rd_gray_full = {~rd_gray_s[`FIFO_LSIZE -: 2], rd_gray_s[`FIFO_LSIZE-2:0]};

    //////////////////////////////////////////////////////////////////////
    // Flag and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr_clk or posedge RST) begin
        if (RST) begin
            full   <= 1'b0;
            wcount <= '0;
        end else begin
            full   <= (wr_gray_nxt == rd_gray_full);   // Set on the filling push
            wcount <= level_t'(wr_bin_nxt - rd_bin_s);  // Wraps mod 2*depth
        end
    end

    // Never more than one lap ahead of the read pointer seen here
    a_no_push_full : assert property (
        @(posedge wr_clk) disable iff (RST)
        ptr_t'(wr_bin - rd_bin_s) <= ptr_t'(`FIFO_DEPTH)
    ) else $error("write pointer moved past full");

endmodule

`default_nettype wire

//--- design/fifo_dpram.sv
`timescale 1ns/100ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_dpram (
    input  logic            wr_clk,
    fifo_port_if.ram        mem
);
    import fifo_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////////////////////////

    data_t ram_q [`FIFO_DEPTH];     // Contents undefined until written

    // Synchronous write in the write domain
    always_ff @(posedge wr_clk) begin
        if (mem.wr_en_mem) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Asynchronous read
    //////////////////////////////////////////////////////////////////////

    // Head word shows up without a read strobe, fall-through style
    assign mem.rd_data = ram_q[mem.rd_addr];

endmodule

`default_nettype wire

//--- design/fifo_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fifo_port_if;
    import fifo_pkg::*;

    // Memory write port, write domain
    logic   wr_en_mem;
    addr_t  wr_addr;
    data_t  wr_data;

    // Memory read port, read domain
    addr_t  rd_addr;
    data_t  rd_data;

    // Registered Gray pointers that cross domains
    ptr_t   wr_gray;        // From write side
    ptr_t   rd_gray;        // From read side

    modport wr_side (
        output wr_en_mem, wr_addr, wr_data, wr_gray,
        input  rd_gray
    );

    modport rd_side (
        output rd_addr, rd_gray,
        input  rd_data, wr_gray
    );

    modport ram (
        input  wr_en_mem, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- design/fifo_pkg.sv
`default_nettype none
`include "fifo_macros.svh"

package fifo_pkg;

    typedef logic [`FIFO_DSIZE-1:0] data_t;   // One stored word
    typedef logic [`FIFO_LSIZE-1:0] addr_t;   // Memory address
    typedef logic [`FIFO_LSIZE:0]   ptr_t;    // Pointer with wrap bit
    typedef logic [`FIFO_LSIZE:0]   level_t;  // Fill level, 0 up to depth

    typedef enum logic [0:0] {
        SEL_LOW  = 1'b0,    // Low watermark
        SEL_HIGH = 1'b1     // High watermark
    } cfg_sel_t;

    // Binary to reflected Gray
    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // Gray back to binary, MSB down
    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[`FIFO_LSIZE] = g[`FIFO_LSIZE];
        for (int i = `FIFO_LSIZE - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

endpackage

`default_nettype wire

//--- design/fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// Word width in bits
`define FIFO_DSIZE 18

// Address width, depth is 2**FIFO_LSIZE
`define FIFO_LSIZE 4

// Flops in each pointer synchronizer
`define FIFO_SYNC_STAGES 2

// Derived depth in words
`define FIFO_DEPTH (1 << `FIFO_LSIZE)

`endif
